// File: rtl/rv_pkg.sv
package rv_pkg;

	// ********************
	// instruction formats
	// ********************

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rtype_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} itype_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} stype_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} btype_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} utype_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jtype_t;

	typedef union packed {
		rtype_t common; // field positions every format shares
		rtype_t rtype;
		itype_t itype;
		stype_t stype;
		btype_t btype;
		utype_t utype;
		jtype_t jtype;
	} instruction_t;

	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// ********************
	// control selects
	// ********************

	typedef enum logic [1:0] {
		NEXT_PC_SEL_PC_4,
		NEXT_PC_SEL_ALU_OUT,
		NEXT_PC_SEL_COMPARE_UNIT_OUT
	} next_pc_sel_t;

	typedef enum logic [2:0] {
		REGFILE_IN_SEL_ALU_OUT,
		REGFILE_IN_SEL_PC_4,
		REGFILE_IN_SEL_MEM_RD,
		REGFILE_IN_SEL_MEM_RD_SEXT8,
		REGFILE_IN_SEL_MEM_RD_SEXT16,
		REGFILE_IN_SEL_CSR_OUT
	} regfile_in_sel_t;

	typedef enum logic {
		MEM_RD_ADDR_SEL_PC,
		MEM_RD_ADDR_SEL_ALU_OUT
	} mem_rd_addr_sel_t;

	typedef enum logic [1:0] {
		ALU_IN1_SEL_REGFILE_OUT1,
		ALU_IN1_SEL_PC,
		ALU_IN1_SEL_IR_CSR_UIMM
	} alu_in1_sel_t;

	typedef enum logic [2:0] {
		ALU_IN2_SEL_REGFILE_OUT2,
		ALU_IN2_SEL_IR_UTYPE_IMM,
		ALU_IN2_SEL_IR_ITYPE_IMM,
		ALU_IN2_SEL_IR_JTYPE_IMM,
		ALU_IN2_SEL_IR_BTYPE_IMM,
		ALU_IN2_SEL_IR_STYPE_IMM,
		ALU_IN2_SEL_CSR_OUT
	} alu_in2_sel_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_SLL = 4'd2,
		ALU_SLT = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SRA = 4'd7,
		ALU_OR = 4'd8,
		ALU_AND = 4'd9,
		ALU_PASS1 = 4'd10,
		ALU_ANDN = 4'd11 // din2 & ~din1
	} alu_op_t;

	// same encoding as branch funct3
	typedef enum logic [2:0] {
		CMP_EQ = 3'b000,
		CMP_NE = 3'b001,
		CMP_LT = 3'b100,
		CMP_GE = 3'b101,
		CMP_LTU = 3'b110,
		CMP_GEU = 3'b111
	} compare_unit_op_t;

	typedef enum logic [1:0] {
		MEM_SIZE_BYTE = 2'b00,
		MEM_SIZE_HALF = 2'b01,
		MEM_SIZE_WORD = 2'b10
	} mem_size_t;

	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MCYCLE = 12'hB00;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

// File: rtl/regfile.sv
`timescale 1ns/1ns

module regfile (
	input logic clk_i,
	input logic [4:0] rs1_i,
	input logic [4:0] rs2_i,
	input logic [4:0] rd_i,
	input logic [31:0] rin_i,
	input logic we_i,
	output logic [31:0] rout1_o,
	output logic [31:0] rout2_o
);
	logic [31:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk_i) begin
		if (we_i && rd_i != 5'd0) begin
			regs[rd_i] <= rin_i;
		end
	end

	always_comb begin
		rout1_o = 32'd0;
		rout2_o = 32'd0;
		if (rs1_i != 5'd0)
			rout1_o = regs[rs1_i];
		if (rs2_i != 5'd0)
			rout2_o = regs[rs2_i];
	end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu (
	input rv_pkg::alu_op_t alu_op_i,
	input logic [31:0] din1_i,
	input logic [31:0] din2_i,
	output logic [31:0] dout_o
);
	logic [4:0] shamt;

	assign shamt = din2_i[4:0];

	always_comb begin
		unique case (alu_op_i)
		rv_pkg::ALU_ADD: dout_o = din1_i + din2_i;
		rv_pkg::ALU_SUB: dout_o = din1_i - din2_i;
		rv_pkg::ALU_SLL: dout_o = din1_i << shamt;
		rv_pkg::ALU_SLT: dout_o = {31'd0, $signed(din1_i) < $signed(din2_i)};
		rv_pkg::ALU_SLTU: dout_o = {31'd0, din1_i < din2_i};
		rv_pkg::ALU_XOR: dout_o = din1_i ^ din2_i;
		rv_pkg::ALU_SRL: dout_o = din1_i >> shamt;
		rv_pkg::ALU_SRA: dout_o = $unsigned($signed(din1_i) >>> shamt);
		rv_pkg::ALU_OR: dout_o = din1_i | din2_i;
		rv_pkg::ALU_AND: dout_o = din1_i & din2_i;
		rv_pkg::ALU_PASS1: dout_o = din1_i; // csrrw
		rv_pkg::ALU_ANDN: dout_o = din2_i & ~din1_i; // csrrc
		default: dout_o = 32'd0;
		endcase
	end

endmodule

// File: rtl/compare_unit.sv
`timescale 1ns/1ns

module compare_unit (
	input rv_pkg::compare_unit_op_t compare_unit_op_i,
	input logic [31:0] in1_i,
	input logic [31:0] in2_i,
	output logic res_o
);
	logic eq;
	logic lt;
	logic ltu;

	assign eq = (in1_i == in2_i);
	assign lt = ($signed(in1_i) < $signed(in2_i));
	assign ltu = (in1_i < in2_i);

	always_comb begin
		unique case (compare_unit_op_i)
		rv_pkg::CMP_EQ: res_o = eq;
		rv_pkg::CMP_NE: res_o = !eq;
		rv_pkg::CMP_LT: res_o = lt;
		rv_pkg::CMP_GE: res_o = !lt;
		rv_pkg::CMP_LTU: res_o = ltu;
		rv_pkg::CMP_GEU: res_o = !ltu;
		default: res_o = 1'b0;
		endcase
	end

endmodule

// File: rtl/csr.sv
`timescale 1ns/1ns

module csr (
	input logic clk_i,
	input logic reset_i,
	input logic [11:0] sel_i,
	input logic [31:0] din_i,
	input logic we_i,
	output logic [31:0] dout_o
);
	logic [31:0] mscratch;
	logic [31:0] mcycle;
	logic sel_mscratch;
	logic sel_mcycle;

	assign sel_mscratch = (sel_i == rv_pkg::CSR_MSCRATCH);
	assign sel_mcycle = (sel_i == rv_pkg::CSR_MCYCLE);

	// mcycle is read-only, writes to it fall through
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			mscratch <= 32'd0;
			mcycle <= 32'd0;
		end else begin
			mcycle <= mcycle + 32'd1;
			if (we_i && sel_mscratch)
				mscratch <= din_i;
		end
	end

	always_comb begin
		if (sel_mscratch)
			dout_o = mscratch;
		else if (sel_mcycle)
			dout_o = mcycle;
		else
			dout_o = 32'd0; // unknown csr
	end

endmodule

// File: rtl/control.sv
`timescale 1ns/1ns

module control (
	input logic clk_i,
	input logic reset_i,
	input rv_pkg::instruction_t ir_i,
	output logic pc_we_o,
	output logic ir_we_o,
	output logic regfile_we_o,
	output logic csr_we_o,
	output rv_pkg::next_pc_sel_t next_pc_sel_o,
	output rv_pkg::regfile_in_sel_t regfile_in_sel_o,
	output rv_pkg::mem_rd_addr_sel_t mem_rd_addr_sel_o,
	output rv_pkg::alu_in1_sel_t alu_in1_sel_o,
	output rv_pkg::alu_in2_sel_t alu_in2_sel_o,
	output rv_pkg::alu_op_t alu_op_o,
	output rv_pkg::compare_unit_op_t compare_unit_op_o,
	output rv_pkg::mem_size_t mem_rd_size_o,
	output rv_pkg::mem_size_t mem_wr_size_o,
	output logic mem_wr_enable_o
);
	logic in_execute; // 0 = fetch, 1 = execute
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign funct3 = ir_i.common.funct3;
	assign funct7 = ir_i.common.funct7;

	function automatic rv_pkg::alu_op_t alu_op_decode(input logic [2:0] f3, input logic alt);
		rv_pkg::alu_op_t op;
		case (f3)
		3'b000: op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
		3'b001: op = rv_pkg::ALU_SLL;
		3'b010: op = rv_pkg::ALU_SLT;
		3'b011: op = rv_pkg::ALU_SLTU;
		3'b100: op = rv_pkg::ALU_XOR;
		3'b101: op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
		3'b110: op = rv_pkg::ALU_OR;
		default: op = rv_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	always_ff @(posedge clk_i) begin
		if (reset_i)
			in_execute <= 1'b0;
		else
			in_execute <= !in_execute;
	end

	// ********************
	// decoder
	// ********************

	always_comb begin
		pc_we_o = 1'b0;
		ir_we_o = 1'b0;
		regfile_we_o = 1'b0;
		csr_we_o = 1'b0;
		next_pc_sel_o = rv_pkg::NEXT_PC_SEL_PC_4;
		regfile_in_sel_o = rv_pkg::REGFILE_IN_SEL_ALU_OUT;
		mem_rd_addr_sel_o = rv_pkg::MEM_RD_ADDR_SEL_PC;
		alu_in1_sel_o = rv_pkg::ALU_IN1_SEL_REGFILE_OUT1;
		alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_REGFILE_OUT2;
		alu_op_o = rv_pkg::ALU_ADD;
		compare_unit_op_o = rv_pkg::CMP_EQ;
		mem_rd_size_o = rv_pkg::MEM_SIZE_WORD;
		mem_wr_size_o = rv_pkg::mem_size_t'(funct3[1:0]);
		mem_wr_enable_o = 1'b0;

		if (!in_execute) begin
			ir_we_o = 1'b1; // read address is pc
		end else begin
			pc_we_o = 1'b1;
			case (ir_i.common.opcode)
			rv_pkg::OPC_LUI: begin
				// uimm only reaches bits 4:0, always zero in a U immediate
				alu_in1_sel_o = rv_pkg::ALU_IN1_SEL_IR_CSR_UIMM;
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_UTYPE_IMM;
				alu_op_o = rv_pkg::ALU_ANDN;
				regfile_we_o = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				alu_in1_sel_o = rv_pkg::ALU_IN1_SEL_PC;
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_UTYPE_IMM;
				regfile_we_o = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				alu_in1_sel_o = rv_pkg::ALU_IN1_SEL_PC;
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_JTYPE_IMM;
				next_pc_sel_o = rv_pkg::NEXT_PC_SEL_ALU_OUT;
				regfile_in_sel_o = rv_pkg::REGFILE_IN_SEL_PC_4;
				regfile_we_o = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_ITYPE_IMM;
				next_pc_sel_o = rv_pkg::NEXT_PC_SEL_ALU_OUT;
				regfile_in_sel_o = rv_pkg::REGFILE_IN_SEL_PC_4;
				regfile_we_o = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				alu_in1_sel_o = rv_pkg::ALU_IN1_SEL_PC;
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_BTYPE_IMM;
				next_pc_sel_o = rv_pkg::NEXT_PC_SEL_COMPARE_UNIT_OUT;
				compare_unit_op_o = rv_pkg::compare_unit_op_t'(funct3);
			end
			rv_pkg::OPC_LOAD: begin
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_ITYPE_IMM;
				mem_rd_addr_sel_o = rv_pkg::MEM_RD_ADDR_SEL_ALU_OUT;
				mem_rd_size_o = rv_pkg::mem_size_t'(funct3[1:0]);
				regfile_we_o = 1'b1;
				case (funct3)
				3'b000: regfile_in_sel_o = rv_pkg::REGFILE_IN_SEL_MEM_RD_SEXT8;
				3'b001: regfile_in_sel_o = rv_pkg::REGFILE_IN_SEL_MEM_RD_SEXT16;
				default: regfile_in_sel_o = rv_pkg::REGFILE_IN_SEL_MEM_RD; // lw, lbu, lhu
				endcase
			end
			rv_pkg::OPC_STORE: begin
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_STYPE_IMM;
				mem_wr_enable_o = 1'b1;
			end
			rv_pkg::OPC_OP_IMM: begin
				alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_IR_ITYPE_IMM;
				alu_op_o = alu_op_decode(funct3, funct3 == 3'b101 && funct7[5]);
				regfile_we_o = 1'b1;
			end
			rv_pkg::OPC_OP: begin
				alu_op_o = alu_op_decode(funct3, funct7[5]);
				regfile_we_o = 1'b1;
			end
			rv_pkg::OPC_SYSTEM: begin
				if (funct3[1:0] != 2'b00) begin
					if (funct3[2])
						alu_in1_sel_o = rv_pkg::ALU_IN1_SEL_IR_CSR_UIMM;
					alu_in2_sel_o = rv_pkg::ALU_IN2_SEL_CSR_OUT;
					case (funct3[1:0])
					2'b01: alu_op_o = rv_pkg::ALU_PASS1;
					2'b10: alu_op_o = rv_pkg::ALU_OR;
					default: alu_op_o = rv_pkg::ALU_ANDN;
					endcase
					regfile_in_sel_o = rv_pkg::REGFILE_IN_SEL_CSR_OUT;
					regfile_we_o = 1'b1;
					// set/clear with rs1 = 0 only reads
					csr_we_o = (funct3[1:0] == 2'b01) || (ir_i.common.rs1 != 5'd0);
				end
			end
			default: ; // fence and unknown opcodes just advance
			endcase
		end
	end

	assert property (@(posedge clk_i) disable iff (reset_i) !(ir_we_o && pc_we_o));
	assert property (@(posedge clk_i) disable iff (reset_i) mem_wr_enable_o |-> in_execute);

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ns

module datapath (
	input logic clk_i,
	input logic reset_i,
	output logic [31:0] mem_rd_addr_o,
	output rv_pkg::mem_size_t mem_rd_size_o,
	input logic [31:0] mem_rd_data_i,
	output logic [31:0] mem_wr_addr_o,
	output logic [31:0] mem_wr_data_o,
	output rv_pkg::mem_size_t mem_wr_size_o,
	output logic mem_wr_enable_o
);
	logic [31:0] pc;
	rv_pkg::instruction_t ir;

	logic [31:0] pc_plus_4;
	logic [31:0] next_pc;
	logic [31:0] alu_din1;
	logic [31:0] alu_din2;
	logic [31:0] alu_dout;
	logic [31:0] rf_rin;
	logic [31:0] rf_rout1;
	logic [31:0] rf_rout2;
	logic [31:0] csr_dout;
	logic cmp_res;

	logic pc_we;
	logic ir_we;
	logic regfile_we;
	logic csr_we;
	rv_pkg::next_pc_sel_t next_pc_sel;
	rv_pkg::regfile_in_sel_t regfile_in_sel;
	rv_pkg::mem_rd_addr_sel_t mem_rd_addr_sel;
	rv_pkg::alu_in1_sel_t alu_in1_sel;
	rv_pkg::alu_in2_sel_t alu_in2_sel;
	rv_pkg::alu_op_t alu_op;
	rv_pkg::compare_unit_op_t cmp_op;

	// ********************
	// submodules
	// ********************

	regfile rf (
		.clk_i(clk_i),
		.rs1_i(ir.common.rs1),
		.rs2_i(ir.common.rs2),
		.rd_i(ir.common.rd),
		.rin_i(rf_rin),
		.we_i(regfile_we),
		.rout1_o(rf_rout1),
		.rout2_o(rf_rout2)
	);

	control ctrl (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ir_i(ir),
		.pc_we_o(pc_we),
		.ir_we_o(ir_we),
		.regfile_we_o(regfile_we),
		.csr_we_o(csr_we),
		.next_pc_sel_o(next_pc_sel),
		.regfile_in_sel_o(regfile_in_sel),
		.mem_rd_addr_sel_o(mem_rd_addr_sel),
		.alu_in1_sel_o(alu_in1_sel),
		.alu_in2_sel_o(alu_in2_sel),
		.alu_op_o(alu_op),
		.compare_unit_op_o(cmp_op),
		.mem_rd_size_o(mem_rd_size_o),
		.mem_wr_size_o(mem_wr_size_o),
		.mem_wr_enable_o(mem_wr_enable_o)
	);

	alu alu_unit (
		.alu_op_i(alu_op),
		.din1_i(alu_din1),
		.din2_i(alu_din2),
		.dout_o(alu_dout)
	);

	compare_unit cmp_unit (
		.compare_unit_op_i(cmp_op),
		.in1_i(rf_rout1),
		.in2_i(rf_rout2),
		.res_o(cmp_res)
	);

	csr csr_unit (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.sel_i(ir.itype.imm),
		.din_i(alu_dout),
		.we_i(csr_we),
		.dout_o(csr_dout)
	);

	// ********************
	// muxes
	// ********************

	assign pc_plus_4 = pc + 32'd4;
	assign mem_wr_addr_o = alu_dout;
	assign mem_wr_data_o = rf_rout2; // memory keeps the low bytes

	always_comb begin
		case (next_pc_sel)
		rv_pkg::NEXT_PC_SEL_ALU_OUT: next_pc = {alu_dout[31:1], 1'b0}; // jalr clears bit 0
		rv_pkg::NEXT_PC_SEL_COMPARE_UNIT_OUT: next_pc = cmp_res ? alu_dout : pc_plus_4;
		default: next_pc = pc_plus_4;
		endcase

		case (regfile_in_sel)
		rv_pkg::REGFILE_IN_SEL_PC_4: rf_rin = pc_plus_4;
		rv_pkg::REGFILE_IN_SEL_MEM_RD: rf_rin = mem_rd_data_i;
		rv_pkg::REGFILE_IN_SEL_MEM_RD_SEXT8:
			rf_rin = {{24{mem_rd_data_i[7]}}, mem_rd_data_i[7:0]};
		rv_pkg::REGFILE_IN_SEL_MEM_RD_SEXT16:
			rf_rin = {{16{mem_rd_data_i[15]}}, mem_rd_data_i[15:0]};
		rv_pkg::REGFILE_IN_SEL_CSR_OUT: rf_rin = csr_dout;
		default: rf_rin = alu_dout;
		endcase

		if (mem_rd_addr_sel == rv_pkg::MEM_RD_ADDR_SEL_ALU_OUT)
			mem_rd_addr_o = alu_dout;
		else
			mem_rd_addr_o = pc;

		case (alu_in1_sel)
		rv_pkg::ALU_IN1_SEL_PC: alu_din1 = pc;
		rv_pkg::ALU_IN1_SEL_IR_CSR_UIMM: alu_din1 = {27'd0, ir.itype.rs1};
		default: alu_din1 = rf_rout1;
		endcase

		case (alu_in2_sel)
		rv_pkg::ALU_IN2_SEL_IR_UTYPE_IMM: alu_din2 = {ir.utype.imm, 12'd0};
		rv_pkg::ALU_IN2_SEL_IR_ITYPE_IMM: alu_din2 = {{20{ir.itype.imm[11]}}, ir.itype.imm};
		rv_pkg::ALU_IN2_SEL_IR_JTYPE_IMM:
			alu_din2 = {{11{ir.jtype.imm20}}, ir.jtype.imm20, ir.jtype.imm19_12,
				ir.jtype.imm11, ir.jtype.imm10_1, 1'b0};
		rv_pkg::ALU_IN2_SEL_IR_BTYPE_IMM:
			alu_din2 = {{19{ir.btype.imm12}}, ir.btype.imm12, ir.btype.imm11,
				ir.btype.imm10_5, ir.btype.imm4_1, 1'b0};
		rv_pkg::ALU_IN2_SEL_IR_STYPE_IMM:
			alu_din2 = {{20{ir.stype.imm_hi[6]}}, ir.stype.imm_hi, ir.stype.imm_lo};
		rv_pkg::ALU_IN2_SEL_CSR_OUT: alu_din2 = csr_dout;
		default: alu_din2 = rf_rout2;
		endcase
	end

	// pc and ir
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= rv_pkg::RESET_PC;
			ir <= '0;
		end else begin
			if (pc_we)
				pc <= next_pc;
			if (ir_we)
				ir <= mem_rd_data_i;
		end
	end

	assert property (@(posedge clk_i) disable iff (reset_i) pc_we |=> pc[1:0] == 2'b00);

endmodule

// File: sim/tb_datapath.sv
`timescale 1ns/1ns

module tb_datapath;

	localparam int MEM_BYTES = 1024;
	localparam logic [31:0] DATA_BASE = 32'h2C0;
	localparam logic [31:0] RESULT_BASE = 32'h300;

	logic clk_i;
	logic reset_i;
	logic [31:0] mem_rd_addr;
	rv_pkg::mem_size_t mem_rd_size;
	logic [31:0] mem_rd_data;
	logic [31:0] mem_wr_addr;
	logic [31:0] mem_wr_data;
	rv_pkg::mem_size_t mem_wr_size;
	logic mem_wr_enable;

	logic [7:0] mem [0:MEM_BYTES-1];
	logic [9:0] rd_a;
	logic [9:0] wr_a;
	logic [31:0] data_words [0:3];
	logic [31:0] prog [$];
	logic [31:0] exp_addr [$]; // store-check table
	logic [1:0] exp_size [$];
	logic [31:0] exp_data [$];

	int errors;
	int store_idx;
	int dyn_count;
	int cycles;
	int cycle_limit;
	int result_off;

	datapath uut (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.mem_rd_addr_o(mem_rd_addr),
		.mem_rd_size_o(mem_rd_size),
		.mem_rd_data_i(mem_rd_data),
		.mem_wr_addr_o(mem_wr_addr),
		.mem_wr_data_o(mem_wr_data),
		.mem_wr_size_o(mem_wr_size),
		.mem_wr_enable_o(mem_wr_enable)
	);

	always #10 clk_i = ~clk_i;

	// ********************
	// memory model
	// ********************

	assign rd_a = mem_rd_addr[9:0];
	assign wr_a = mem_wr_addr[9:0];

	always_comb begin
		case (mem_rd_size)
		rv_pkg::MEM_SIZE_BYTE: mem_rd_data = {24'd0, mem[rd_a]};
		rv_pkg::MEM_SIZE_HALF:
			mem_rd_data = {16'd0, mem[{rd_a[9:1], 1'b1}], mem[{rd_a[9:1], 1'b0}]};
		default:
			mem_rd_data = {mem[{rd_a[9:2], 2'd3}], mem[{rd_a[9:2], 2'd2}],
				mem[{rd_a[9:2], 2'd1}], mem[{rd_a[9:2], 2'd0}]};
		endcase
	end

	always @(posedge clk_i) begin
		if (mem_wr_enable) begin
			mem[wr_a] <= mem_wr_data[7:0];
			if (mem_wr_size != rv_pkg::MEM_SIZE_BYTE)
				mem[wr_a + 10'd1] <= mem_wr_data[15:8];
			if (mem_wr_size == rv_pkg::MEM_SIZE_WORD) begin
				mem[wr_a + 10'd2] <= mem_wr_data[23:16];
				mem[wr_a + 10'd3] <= mem_wr_data[31:24];
			end
		end
	end

	// ********************
	// encoders
	// ********************

	function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
	endfunction

	function automatic logic [31:0] here_addr();
		return rv_pkg::RESET_PC + 32'(prog.size() * 4);
	endfunction

	function automatic logic [31:0] size_mask(input logic [1:0] size);
		if (size == rv_pkg::MEM_SIZE_BYTE)
			return 32'h0000_00FF;
		else if (size == rv_pkg::MEM_SIZE_HALF)
			return 32'h0000_FFFF;
		return 32'hFFFF_FFFF;
	endfunction

	function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
		3'b000: return x == y;
		3'b001: return x != y;
		3'b100: return $signed(x) < $signed(y);
		3'b101: return $signed(x) >= $signed(y);
		3'b110: return x < y;
		default: return x >= y;
		endcase
	endfunction

	// ********************
	// program builder
	// ********************

	task automatic add_instr(input logic [31:0] instr, input bit runs);
		prog.push_back(instr);
		if (runs)
			dyn_count++; // skipped words don't count
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [1:0] size,
		input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_size.push_back(size);
		exp_data.push_back(data);
	endtask

	task automatic store_word(input logic [4:0] rs, input logic [31:0] value);
		add_instr(encode_s(12'(result_off), rs, 5'd2, 3'b010), 1'b1);
		expect_store(RESULT_BASE + 32'(result_off), rv_pkg::MEM_SIZE_WORD, value);
		result_off += 4;
	endtask

	task automatic alu_result(input logic [31:0] instr, input logic [31:0] value);
		add_instr(instr, 1'b1); // rd is x11
		store_word(5'd11, value);
	endtask

	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] v1, input logic [31:0] v2, input int tag);
		bit taken;
		taken = branch_taken(f3, v1, v2);
		add_instr(encode_i(12'(256 + tag), 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM), 1'b1);
		add_instr(encode_b(13'd8, rs2, rs1, f3), 1'b1);
		add_instr(encode_i(12'(512 + tag), 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM), !taken);
		store_word(5'd5, taken ? 32'(256 + tag) : 32'(512 + tag));
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [19:0] u1;
		logic [19:0] u2;
		logic [11:0] imm;
		logic [31:0] simm;
		logic [4:0] sh;
		logic [31:0] pc_here;
		logic [2:0] f3;
		int slot;
		a = data_words[0];
		b = data_words[1];
		c = data_words[2];
		d = data_words[3];
		u1 = 20'($urandom);
		u2 = 20'($urandom);
		imm = 12'($urandom);
		simm = {{20{imm[11]}}, imm};
		sh = 5'($urandom);

		// straight-line start without loads
		add_instr(encode_i(DATA_BASE[11:0], 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM), 1'b1);
		add_instr(encode_i(RESULT_BASE[11:0], 5'd0, 3'b000, 5'd2, rv_pkg::OPC_OP_IMM), 1'b1);
		add_instr(encode_u(u1, 5'd9, rv_pkg::OPC_LUI), 1'b1);
		pc_here = here_addr();
		add_instr(encode_u(u2, 5'd10, rv_pkg::OPC_AUIPC), 1'b1);
		add_instr(encode_i(12'd0, 5'd1, 3'b010, 5'd3, rv_pkg::OPC_LOAD), 1'b1);
		add_instr(encode_i(12'd4, 5'd1, 3'b010, 5'd4, rv_pkg::OPC_LOAD), 1'b1);
		store_word(5'd9, {u1, 12'd0});
		store_word(5'd10, pc_here + {u2, 12'd0});

		// register ops on x3 = a and x4 = b
		alu_result(encode_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd11), a + b);
		alu_result(encode_r(7'h20, 5'd4, 5'd3, 3'b000, 5'd11), a - b);
		alu_result(encode_r(7'h00, 5'd4, 5'd3, 3'b001, 5'd11), a << b[4:0]);
		alu_result(encode_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd11), {31'd0, $signed(a) < $signed(b)});
		alu_result(encode_r(7'h00, 5'd3, 5'd4, 3'b010, 5'd11), {31'd0, $signed(b) < $signed(a)});
		alu_result(encode_r(7'h00, 5'd4, 5'd3, 3'b011, 5'd11), {31'd0, a < b});
		alu_result(encode_r(7'h00, 5'd3, 5'd4, 3'b011, 5'd11), {31'd0, b < a});
		alu_result(encode_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd11), a ^ b);
		alu_result(encode_r(7'h00, 5'd3, 5'd4, 3'b101, 5'd11), b >> a[4:0]);
		alu_result(encode_r(7'h20, 5'd3, 5'd4, 3'b101, 5'd11), $signed(b) >>> a[4:0]);
		alu_result(encode_r(7'h00, 5'd4, 5'd3, 3'b110, 5'd11), a | b);
		alu_result(encode_r(7'h00, 5'd4, 5'd3, 3'b111, 5'd11), a & b);

		// immediate ops
		alu_result(encode_i(imm, 5'd3, 3'b000, 5'd11, rv_pkg::OPC_OP_IMM), a + simm);
		alu_result(encode_i(imm, 5'd4, 3'b010, 5'd11, rv_pkg::OPC_OP_IMM),
			{31'd0, $signed(b) < $signed(simm)});
		alu_result(encode_i(imm, 5'd3, 3'b011, 5'd11, rv_pkg::OPC_OP_IMM), {31'd0, a < simm});
		alu_result(encode_i(imm, 5'd3, 3'b100, 5'd11, rv_pkg::OPC_OP_IMM), a ^ simm);
		alu_result(encode_i(imm, 5'd4, 3'b110, 5'd11, rv_pkg::OPC_OP_IMM), b | simm);
		alu_result(encode_i(imm, 5'd3, 3'b111, 5'd11, rv_pkg::OPC_OP_IMM), a & simm);
		alu_result(encode_i({7'h00, sh}, 5'd3, 3'b001, 5'd11, rv_pkg::OPC_OP_IMM), a << sh);
		alu_result(encode_i({7'h00, sh}, 5'd4, 3'b101, 5'd11, rv_pkg::OPC_OP_IMM), b >> sh);
		alu_result(encode_i({7'h20, sh}, 5'd4, 3'b101, 5'd11, rv_pkg::OPC_OP_IMM),
			$signed(b) >>> sh);

		// c has negative byte lanes and d positive ones
		alu_result(encode_i(12'd9, 5'd1, 3'b000, 5'd11, rv_pkg::OPC_LOAD),
			{{24{c[15]}}, c[15:8]});
		alu_result(encode_i(12'd10, 5'd1, 3'b001, 5'd11, rv_pkg::OPC_LOAD),
			{{16{c[31]}}, c[31:16]});
		alu_result(encode_i(12'd11, 5'd1, 3'b100, 5'd11, rv_pkg::OPC_LOAD), {24'd0, c[31:24]});
		alu_result(encode_i(12'd8, 5'd1, 3'b101, 5'd11, rv_pkg::OPC_LOAD), {16'd0, c[15:0]});
		alu_result(encode_i(12'd12, 5'd1, 3'b010, 5'd11, rv_pkg::OPC_LOAD), d);
		alu_result(encode_i(12'd12, 5'd1, 3'b000, 5'd11, rv_pkg::OPC_LOAD),
			{{24{d[7]}}, d[7:0]});
		alu_result(encode_i(12'd14, 5'd1, 3'b001, 5'd11, rv_pkg::OPC_LOAD),
			{{16{d[31]}}, d[31:16]});

		// sb and sh into empty slots and the words read back
		slot = result_off;
		add_instr(encode_s(12'(slot + 1), 5'd3, 5'd2, 3'b000), 1'b1);
		expect_store(RESULT_BASE + 32'(slot + 1), rv_pkg::MEM_SIZE_BYTE, {24'd0, a[7:0]});
		add_instr(encode_s(12'(slot + 6), 5'd4, 5'd2, 3'b001), 1'b1);
		expect_store(RESULT_BASE + 32'(slot + 6), rv_pkg::MEM_SIZE_HALF, {16'd0, b[15:0]});
		result_off += 8;
		alu_result(encode_i(12'(slot), 5'd2, 3'b010, 5'd11, rv_pkg::OPC_LOAD),
			{16'd0, a[7:0], 8'd0});
		alu_result(encode_i(12'(slot + 4), 5'd2, 3'b010, 5'd11, rv_pkg::OPC_LOAD),
			{b[15:0], 16'd0});

		// both outcomes of each branch condition
		for (int i = 0; i < 6; i++) begin
			f3 = (i < 2) ? 3'(i) : 3'(i + 2);
			if (i < 2) begin
				branch_case(f3, 5'd3, 5'd3, a, a, 2 * i);
				branch_case(f3, 5'd3, 5'd4, a, b, 2 * i + 1);
			end else begin
				branch_case(f3, 5'd3, 5'd4, a, b, 2 * i);
				branch_case(f3, 5'd4, 5'd3, b, a, 2 * i + 1);
			end
		end

		// jal over one word
		add_instr(encode_i(12'h111, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM), 1'b1);
		pc_here = here_addr();
		add_instr(encode_j(21'd8, 5'd6), 1'b1);
		add_instr(encode_i(12'h222, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM), 1'b0);
		store_word(5'd5, 32'h111);
		store_word(5'd6, pc_here + 32'd4);

		// jalr over two words
		add_instr(encode_i(12'h333, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM), 1'b1);
		pc_here = here_addr();
		add_instr(encode_u(20'd0, 5'd7, rv_pkg::OPC_AUIPC), 1'b1);
		add_instr(encode_i(12'd16, 5'd7, 3'b000, 5'd8, rv_pkg::OPC_JALR), 1'b1);
		add_instr(encode_i(12'h444, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM), 1'b0);
		add_instr(encode_i(12'h555, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM), 1'b0);
		store_word(5'd5, 32'h333);
		store_word(5'd8, pc_here + 32'd8);
		store_word(5'd7, pc_here);

		// each csr access returns the old value
		alu_result(encode_i(rv_pkg::CSR_MSCRATCH, 5'd3, 3'b001, 5'd11, rv_pkg::OPC_SYSTEM), 32'd0);
		alu_result(encode_i(rv_pkg::CSR_MSCRATCH, 5'd4, 3'b010, 5'd11, rv_pkg::OPC_SYSTEM), a);
		alu_result(encode_i(rv_pkg::CSR_MSCRATCH, 5'd3, 3'b011, 5'd11, rv_pkg::OPC_SYSTEM), a | b);
		alu_result(encode_i(rv_pkg::CSR_MSCRATCH, 5'd21, 3'b101, 5'd11, rv_pkg::OPC_SYSTEM),
			(a | b) & ~a);
		alu_result(encode_i(rv_pkg::CSR_MSCRATCH, 5'd0, 3'b010, 5'd11, rv_pkg::OPC_SYSTEM), 32'd21);
		add_instr(encode_i(rv_pkg::CSR_MCYCLE, 5'd0, 3'b010, 5'd13, rv_pkg::OPC_SYSTEM), 1'b1);
		add_instr(encode_i(rv_pkg::CSR_MCYCLE, 5'd0, 3'b010, 5'd14, rv_pkg::OPC_SYSTEM), 1'b1);
		alu_result(encode_r(7'h00, 5'd14, 5'd13, 3'b011, 5'd11), 32'd1); // second read larger

		add_instr(encode_j(21'd0, 5'd0), 1'b1); // park
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// ********************
	// store monitor
	// ********************

	always @(negedge clk_i) begin
		if (reset_i) begin
			check_value("mem_wr_enable_o", 32'd0, {31'd0, mem_wr_enable});
		end else if (mem_wr_enable) begin
			if (store_idx < exp_addr.size()) begin
				check_value("mem_wr_addr_o", exp_addr[store_idx], mem_wr_addr);
				check_value("mem_wr_size_o", {30'd0, exp_size[store_idx]}, {30'd0, mem_wr_size});
				check_value("mem_wr_data_o", exp_data[store_idx],
					mem_wr_data & size_mask(exp_size[store_idx]));
			end else begin
				errors++;
				$display("unexpected store to %h after the last expected store", mem_wr_addr);
			end
			store_idx++;
		end
	end

	always @(posedge clk_i) begin
		if (!reset_i) begin
			cycles <= cycles + 1;
			if (cycles >= cycle_limit) begin
				$display("program did not finish within %0d cycles", cycle_limit);
				$display("errors: %0d, stores seen: %0d of %0d", errors + 1, store_idx,
					exp_addr.size());
				$display("TEST FAILED");
				$finish;
			end
		end
	end

	initial begin
		void'($urandom(17681));
		clk_i = 1'b0;
		reset_i = 1'b1;
		errors = 0;
		store_idx = 0;
		dyn_count = 0;
		cycles = 0;
		result_off = 0;
		for (int i = 0; i < MEM_BYTES; i++)
			mem[i] = 8'h00;
		for (int i = 0; i < 4; i++)
			data_words[i] = $urandom;
		data_words[0][31] = 1'b0; // signed and unsigned order differ
		data_words[1][31] = 1'b1;
		data_words[2] = data_words[2] | 32'h8080_8080;
		data_words[3] = data_words[3] & 32'h7F7F_7F7F;

		build_program();
		if (here_addr() > DATA_BASE) begin
			errors++;
			$display("program runs into the data block at %h", DATA_BASE);
		end
		for (int i = 0; i < prog.size(); i++)
			for (int j = 0; j < 4; j++)
				mem[rv_pkg::RESET_PC + 4 * i + j] = prog[i][8 * j +: 8];
		for (int i = 0; i < 4; i++)
			for (int j = 0; j < 4; j++)
				mem[DATA_BASE + 4 * i + j] = data_words[i][8 * j +: 8];
		cycle_limit = 2 * dyn_count + 50;

		repeat (2) @(posedge clk_i);
		reset_i <= 1'b0;

		// fetch address steps by 4 every two cycles
		for (int k = 0; k < 8; k++) begin
			@(negedge clk_i);
			check_value("mem_rd_addr_o", rv_pkg::RESET_PC + 32'(4 * (k / 2)), mem_rd_addr);
			if (k % 2 == 0)
				check_value("mem_rd_size_o", {30'd0, rv_pkg::MEM_SIZE_WORD},
					{30'd0, mem_rd_size}); // instruction fetch reads a word
			check_value("mem_wr_enable_o", 32'd0, {31'd0, mem_wr_enable});
		end

		while (store_idx < exp_addr.size())
			@(posedge clk_i);
		repeat (10) @(posedge clk_i); // catch stray stores

		$display("errors: %0d, stores seen: %0d of %0d", errors, store_idx, exp_addr.size());
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sim.f
rtl/rv_pkg.sv
rtl/regfile.sv
rtl/alu.sv
rtl/compare_unit.sv
rtl/csr.sv
rtl/control.sv
rtl/datapath.sv
sim/tb_datapath.sv
